/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_plru.sv
verilog/dcache_store.sv
verilog/dcache_bus.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
test/tb_clock.sv
test/tb_dcache.sv

/* test/dcache_tests.txt */
# kind address strobe wdata expected_load
# kind: l/s = load/store, then h = hit, m = clean miss, w = miss with dirty writeback
lm 00000104 0 00000000 fffffefb
lh 00000110 0 00000000 fffffeef
lh 0000011c 0 00000000 fffffee3
sh 00000108 3 0000abcd 00000000
lh 00000108 0 00000000 ffffabcd
sm 00000224 c 12340000 00000000
lh 00000224 0 00000000 1234fddb
lh 00000220 0 00000000 fffffddf
sh 00000228 4 00560000 00000000
lh 00000228 0 00000000 ff56fdd7
lm 00001040 0 00000000 ffffefbf
lm 00002040 0 00000000 ffffdfbf
lm 00003040 0 00000000 ffffcfbf
lm 00004040 0 00000000 ffffbfbf
lh 00001040 0 00000000 ffffefbf
lm 00005040 0 00000000 ffffafbf
lm 00002040 0 00000000 ffffdfbf
lh 00001040 0 00000000 ffffefbf
sm 00000408 f 5a5aa5a5 00000000
lm 00001400 0 00000000 ffffebff
lm 00002400 0 00000000 ffffdbff
lm 00003400 0 00000000 ffffcbff
lw 00004400 0 00000000 ffffbbff
lm 00000408 0 00000000 5a5aa5a5
lh 0000041c 0 00000000 fffffbe3

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD = 4.0   // ns
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end
endmodule

/* test/tb_dcache.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module tb_dcache;
    localparam int WAIT_LIMIT = 200;   // cycles per wait
    localparam dcache_pkg::addr_t LINE_MASK = (1 << `DC_OFFSET_W) - 1;
    localparam dcache_pkg::addr_t SET_MASK  = (1 << (`DC_INDEX_W + `DC_OFFSET_W)) - 1;

    logic clk, rst, req_valid, req_ready, rsp_valid;
    dcache_pkg::cpu_req_t req;
    dcache_pkg::word_t    rsp_rdata, rdata;
    dcache_pkg::axi_ar_t  ar;
    dcache_pkg::axi_aw_t  aw;
    dcache_pkg::axi_w_t   w;
    logic arvalid, arready, rlast, rvalid, rready, awvalid, awready, wvalid, wready;
    logic bvalid, bready;

    dcache_pkg::word_t mem_words [dcache_pkg::addr_t];  // only written words live here
    dcache_pkg::addr_t cur_line;                        // line of the request in flight
    logic [31:0]       lcg_state = 32'h540cb2ee;
    int ar_bursts, aw_bursts, b_count, b_count_at_ar;

    tb_clock tb_clock_inst (.clk);

    dcache_top dcache_top_inst (.*);

    function automatic int pick_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[17:16]);   // 0 to 3 cycles
    endfunction

    function automatic dcache_pkg::word_t read_mem(dcache_pkg::addr_t a);
        if (mem_words.exists(a)) return mem_words[a];
        return ~a;   // untouched memory holds the inverted address
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t exp);
        if (got !== exp) stop_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input dcache_pkg::addr_t got,
                              input dcache_pkg::addr_t exp);
        if (got !== exp) stop_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_beats(input string name, input dcache_pkg::word_sel_t got,
                               input dcache_pkg::word_sel_t exp);
        if (got !== exp) stop_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_strb(input string name, input dcache_pkg::strb_t got,
                              input dcache_pkg::strb_t exp);
        if (got !== exp) stop_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) stop_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // one request through the cache
    // kind[15:8] tells load or store and kind[7:0] the expected path
    task automatic run_op(input logic [15:0] kind, input dcache_pkg::addr_t addr,
                          input dcache_pkg::strb_t strb, input dcache_pkg::word_t wdata,
                          input dcache_pkg::word_t exp_word);
        int waited, reads0, writes0, done0, exp_reads, exp_writes;
        reads0     = ar_bursts;
        writes0    = aw_bursts;
        done0      = b_count;
        exp_reads  = (kind[7:0] == "h") ? 0 : 1;
        exp_writes = (kind[7:0] == "w") ? 1 : 0;
        cur_line   = addr & ~LINE_MASK;
        req        = '{addr: addr, write: kind[15:8] == "s", strb: strb, wdata: wdata};
        req_valid  = 1'b1;
        waited     = 0;
        while (!req_ready) begin
            if (waited == WAIT_LIMIT) stop_run("request was not accepted in time");
            waited++;
            step();
        end
        step();   // handshake edge
        req_valid = 1'b0;
        if (kind[7:0] == "h") check_flag("rsp_valid one cycle after hit", rsp_valid, 1'b1);
        waited = 0;
        while (!rsp_valid) begin
            if (waited == WAIT_LIMIT) stop_run("no response to a missed request");
            waited++;
            step();
        end
        check_flag("req_ready while busy", req_ready, 1'b0);
        if (!req.write) check_word("rsp_rdata", rsp_rdata, exp_word);
        check_beats("read bursts", 3'(ar_bursts - reads0), 3'(exp_reads));
        check_beats("write bursts", 3'(aw_bursts - writes0), 3'(exp_writes));
        if (exp_reads == 1) begin
            check_beats("writebacks before refill", 3'(b_count_at_ar - done0), 3'(exp_writes));
        end
        step();
        check_flag("rsp_valid after response", rsp_valid, 1'b0);
    endtask

    // memory model deciding all channels 1 ns after each edge
    initial begin : mem_model
        int ar_wait, r_wait, aw_wait, w_wait, b_wait;
        logic rd_busy, wr_busy, b_due;
        dcache_pkg::addr_t rd_addr, wr_addr;
        dcache_pkg::word_sel_t rd_beat, wr_beat;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        rd_busy = 1'b0;
        wr_busy = 1'b0;
        b_due   = 1'b0;
        ar_wait = pick_delay();
        aw_wait = pick_delay();
        forever begin
            step();
            rvalid = 1'b0;   // read data before read address, so beats start a cycle later
            if (rd_busy) begin
                if (r_wait > 0) r_wait--;
                else begin
                    rvalid = 1'b1;
                    rdata  = read_mem(rd_addr + (32'(rd_beat) << 2));
                    rlast  = (rd_beat == 3'd7);
                    if (rready) begin
                        if (rlast) rd_busy = 1'b0;
                        rd_beat++;
                        r_wait = pick_delay();
                    end
                end
            end
            arready = 1'b0;
            if (arvalid && !rd_busy) begin
                if (ar_wait > 0) ar_wait--;
                else begin
                    arready = 1'b1;
                    rd_busy = 1'b1;
                    rd_addr = ar.addr;
                    rd_beat = '0;
                    ar_bursts++;
                    b_count_at_ar = b_count;
                    check_addr("ar.addr", ar.addr, cur_line);
                    check_beats("ar.len", ar.len[2:0], 3'd7);
                    if (ar.len[3]) stop_run("read burst length field is above 7");
                    ar_wait = pick_delay();
                    r_wait  = pick_delay();
                end
            end
            bvalid = 1'b0;
            if (b_due) begin
                if (b_wait > 0) b_wait--;
                else begin
                    bvalid = 1'b1;
                    if (bready) begin
                        b_due   = 1'b0;
                        wr_busy = 1'b0;
                        b_count++;
                    end
                end
            end
            wready = 1'b0;
            if (wr_busy && !b_due && wvalid) begin
                if (w_wait > 0) w_wait--;
                else begin
                    wready = 1'b1;
                    mem_words[wr_addr + (32'(wr_beat) << 2)] = w.data;
                    check_strb("w.strb", w.strb, 4'hf);
                    if (w.last) begin
                        check_beats("wlast beat", wr_beat, 3'd7);
                        b_due  = 1'b1;
                        b_wait = pick_delay();
                    end else if (wr_beat == 3'd7) begin
                        stop_run("wlast missing on the eighth write beat");
                    end
                    wr_beat++;
                    w_wait = pick_delay();
                end
            end
            awready = 1'b0;
            if (awvalid && !wr_busy) begin
                if (aw_wait > 0) aw_wait--;
                else begin
                    awready = 1'b1;
                    wr_busy = 1'b1;
                    wr_addr = aw.addr;
                    wr_beat = '0;
                    aw_bursts++;
                    // victim sits line aligned in the same set
                    check_addr("aw.addr set bits", aw.addr & SET_MASK, cur_line & SET_MASK);
                    check_beats("aw.len", aw.len[2:0], 3'd7);
                    if (aw.len[3]) stop_run("write burst length field is above 7");
                    aw_wait = pick_delay();
                    w_wait  = pick_delay();
                end
            end
        end
    end

    initial begin
        int fd, got, n_ops;
        string line;
        logic [15:0] kind;
        dcache_pkg::addr_t addr;
        dcache_pkg::strb_t strb;
        dcache_pkg::word_t wdata, exp_word;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        cur_line  = '0;
        n_ops     = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag("req_ready after reset", req_ready, 1'b1);
        check_flag("rsp_valid after reset", rsp_valid, 1'b0);
        check_flag("bus valids after reset", arvalid | awvalid | wvalid | rready | bready, 1'b0);
        fd = $fopen("test/dcache_tests.txt", "r");
        if (fd == 0) stop_run("cannot open test/dcache_tests.txt");
        while ($fgets(line, fd) > 0) begin
            got = $sscanf(line, "%s %h %h %h %h", kind, addr, strb, wdata, exp_word);
            if (got == 5) begin   // header lines never parse fully
                run_op(kind, addr, strb, wdata, exp_word);
                n_ops++;
            end
        end
        $fclose(fd);
        step();
        if (n_ops == 0) begin
            stop_run("test file held no operations");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

/* verilog/dcache_bus.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_bus (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  refill_start,
    input  dcache_pkg::addr_t     refill_addr,
    input  logic                  wb_start,
    input  dcache_pkg::addr_t     wb_addr,
    input  dcache_pkg::word_t     wb_word,
    input  logic                  arready,
    input  dcache_pkg::word_t     rdata,
    input  logic                  rlast,
    input  logic                  rvalid,
    input  logic                  awready,
    input  logic                  wready,
    input  logic                  bvalid,
    output dcache_pkg::axi_ar_t   ar,
    output logic                  arvalid,
    output logic                  rready,
    output dcache_pkg::word_sel_t fill_beat,
    output logic                  fill_valid,
    output dcache_pkg::word_t     fill_data,
    output logic                  refill_done,
    output dcache_pkg::axi_aw_t   aw,
    output logic                  awvalid,
    output dcache_pkg::axi_w_t    w,
    output logic                  wvalid,
    output logic                  bready,
    output dcache_pkg::word_sel_t wb_beat,
    output logic                  wb_done
);
    logic                  read_req, raddr_rcv;              // read burst in progress
    logic                  write_req, waddr_rcv, wdata_rcv;  // write burst in progress
    logic                  r_fire, w_fire;
    dcache_pkg::word_sel_t rcnt, wcnt;
    dcache_pkg::addr_t     ar_addr, aw_addr;

    assign arvalid     = read_req && !raddr_rcv;
    assign rready      = raddr_rcv;
    assign r_fire      = raddr_rcv && rvalid;
    assign refill_done = r_fire && rlast;
    assign fill_valid  = r_fire;
    assign fill_beat   = rcnt;
    assign fill_data   = rdata;
    assign ar          = '{addr: ar_addr, len: 4'(`DC_BURST_LEN)};

    assign awvalid = write_req && !waddr_rcv;
    assign wvalid  = waddr_rcv && !wdata_rcv;   // data only after the address
    assign w_fire  = wvalid && wready;
    assign bready  = wdata_rcv;
    assign wb_done = bvalid && wdata_rcv;
    assign wb_beat = w_fire ? wcnt + 1'b1 : wcnt;
    assign aw      = '{addr: aw_addr, len: 4'(`DC_BURST_LEN)};
    assign w       = '{data: wb_word, strb: 4'hf, last: wcnt == `DC_BURST_LEN};

    always_ff @(posedge clk) begin
        if (refill_start) ar_addr <= refill_addr;
        if (wb_start) aw_addr <= wb_addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_req  <= 1'b0;
            raddr_rcv <= 1'b0;
            rcnt      <= '0;
        end else begin
            if (refill_start) read_req <= 1'b1;
            else if (refill_done) read_req <= 1'b0;
            if (arvalid && arready) raddr_rcv <= 1'b1;
            else if (refill_done) raddr_rcv <= 1'b0;
            if (r_fire) rcnt <= refill_done ? '0 : rcnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            write_req <= 1'b0;
            waddr_rcv <= 1'b0;
            wdata_rcv <= 1'b0;
            wcnt      <= '0;
        end else begin
            if (wb_start) write_req <= 1'b1;
            else if (wb_done) write_req <= 1'b0;
            if (awvalid && awready) waddr_rcv <= 1'b1;
            else if (wb_done) waddr_rcv <= 1'b0;
            if (w_fire && w.last) wdata_rcv <= 1'b1;
            else if (wb_done) wdata_rcv <= 1'b0;
            if (w_fire) wcnt <= wcnt + 1'b1;   // wraps to 0 after the eighth beat
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar));

    // last beat closes the data phase
    wlast_end: assert property (@(posedge clk) disable iff (rst)
        w_fire && w.last |=> !wvalid);

endmodule

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  dcache_pkg::cpu_req_t  req,
    input  logic                  hit,
    input  dcache_pkg::way_t      hit_way,
    input  dcache_pkg::way_t      victim_way,
    input  logic                  victim_dirty,
    input  dcache_pkg::tag_t      victim_tag,
    input  dcache_pkg::word_sel_t fill_beat,
    input  logic                  fill_valid,
    input  dcache_pkg::word_t     fill_data,
    input  logic                  refill_done,
    input  logic                  wb_done,
    input  dcache_pkg::word_t     hit_word,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output dcache_pkg::word_t     rsp_rdata,
    output logic                  lookup_en,
    output dcache_pkg::cpu_req_t  cur_req,
    output logic                  store_we,
    output logic                  fill_we,
    output dcache_pkg::word_t     fill_wdata,
    output logic                  line_valid_set,
    output logic                  plru_access,
    output dcache_pkg::way_t      plru_way,
    output logic                  refill_start,
    output logic                  wb_start,
    output dcache_pkg::addr_t     refill_addr,
    output dcache_pkg::addr_t     wb_addr
);
    dcache_pkg::ctrl_state_t state, state_next;
    dcache_pkg::cpu_req_t    req_q;      // request being served
    dcache_pkg::word_t       load_word;  // caught from the refill burst
    dcache_pkg::word_t       byte_mask;
    dcache_pkg::word_sel_t   req_word;
    dcache_pkg::index_t      req_index;
    logic                    lookup_hit;

    assign req_ready  = (state == dcache_pkg::IDLE);
    assign lookup_en  = req_valid && req_ready;
    assign cur_req    = req_ready ? req : req_q; // arrays read with the incoming index
    assign req_word   = req_q.addr[`DC_OFFSET_W-1:2];
    assign req_index  = req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign lookup_hit = (state == dcache_pkg::LOOKUP) && hit;
    assign byte_mask  = {{8{req_q.strb[3]}}, {8{req_q.strb[2]}},
                         {8{req_q.strb[1]}}, {8{req_q.strb[0]}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) req_q <= req;
        if (fill_valid && fill_beat == req_word) load_word <= fill_data;
    end

    always_comb begin
        state_next   = state;
        refill_start = 1'b0;
        wb_start     = 1'b0;
        case (state)
            dcache_pkg::IDLE: if (lookup_en) state_next = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP: begin
                if (hit) begin
                    state_next = dcache_pkg::IDLE;
                end else if (victim_dirty) begin
                    wb_start   = 1'b1;   // old line goes out first
                    state_next = dcache_pkg::WRITEBACK;
                end else begin
                    refill_start = 1'b1;
                    state_next   = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::WRITEBACK: begin
                if (wb_done) begin
                    refill_start = 1'b1;
                    state_next   = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REFILL: if (refill_done) state_next = dcache_pkg::DONE;
            default: state_next = dcache_pkg::IDLE;
        endcase
    end

    assign rsp_valid = lookup_hit || (state == dcache_pkg::DONE);
    assign rsp_rdata = (state == dcache_pkg::DONE) ? load_word : hit_word;

    // store miss bytes land in the beat at the word offset
    assign fill_we    = (state == dcache_pkg::REFILL) && fill_valid;
    assign fill_wdata = (req_q.write && fill_beat == req_word) ?
                        (fill_data & ~byte_mask) | (req_q.wdata & byte_mask) : fill_data;

    assign line_valid_set = (state == dcache_pkg::REFILL) && refill_done;
    assign store_we       = req_q.write && (lookup_hit || line_valid_set); // also marks dirty
    assign plru_access    = lookup_hit || line_valid_set;
    assign plru_way       = (state == dcache_pkg::LOOKUP) ? hit_way : victim_way;

    assign refill_addr = {req_q.addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    assign wb_addr     = {victim_tag, req_index, {`DC_OFFSET_W{1'b0}}};

    // one response per request, then back to idle
    rsp_once: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> (state != dcache_pkg::IDLE) ##1 (state == dcache_pkg::IDLE));

    // refill waits for the writeback response
    refill_after_wb: assert property (@(posedge clk) disable iff (rst)
        wb_start |=> !refill_start until wb_done);

endmodule

/* verilog/dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cache geometry
`define DC_ADDR_W     32
`define DC_INDEX_W    7   // 128 sets
`define DC_OFFSET_W   5   // 32-byte lines
`define DC_WAYS       4
`define DC_LINE_WORDS 8

// address bits left for the tag
`define DC_TAG_W (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

// burst length field, beats minus one
`define DC_BURST_LEN (`DC_LINE_WORDS - 1)

`endif

/* verilog/dcache_pkg.sv */
`include "dcache_params.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]               addr_t;
    typedef logic [31:0]                         word_t;
    typedef logic [3:0]                          strb_t;
    typedef logic [`DC_TAG_W-1:0]                tag_t;
    typedef logic [`DC_INDEX_W-1:0]              index_t;
    typedef logic [$clog2(`DC_LINE_WORDS)-1:0]   word_sel_t; // also the beat number
    typedef logic [$clog2(`DC_WAYS)-1:0]         way_t;

    typedef struct packed {
        addr_t addr;
        logic  write;   // store when set
        strb_t strb;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        addr_t      addr;   // line aligned
        logic [3:0] len;
    } axi_ar_t;

    typedef struct packed {
        addr_t      addr;
        logic [3:0] len;
    } axi_aw_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, REFILL, DONE} ctrl_state_t;

endpackage

/* verilog/dcache_plru.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_plru (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::index_t index,
    input  logic               access,
    input  dcache_pkg::way_t   way,
    output dcache_pkg::way_t   victim_way
);
    localparam int SETS = 1 << `DC_INDEX_W;

    logic [2:0] tree [SETS];   // bit 0 root, bit 1 low half, bit 2 high half
    logic [2:0] bits;

    assign bits       = tree[index];
    assign victim_way = {bits[0], bits[0] ? bits[2] : bits[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (access) begin
            tree[index][0] <= ~way[1];   // point at the other half
            if (!way[1]) begin
                tree[index][1] <= ~way[0];
            end else begin
                tree[index][2] <= ~way[0];
            end
        end
    end

endmodule

/* verilog/dcache_store.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_store (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  lookup_en,
    input  dcache_pkg::addr_t     req_addr,
    input  dcache_pkg::way_t      victim_way,
    input  logic                  store_we,
    input  dcache_pkg::way_t      store_way,
    input  dcache_pkg::strb_t     store_strb,
    input  dcache_pkg::word_t     store_wdata,
    input  logic                  fill_we,
    input  dcache_pkg::word_sel_t fill_beat,
    input  dcache_pkg::word_t     fill_wdata,
    input  logic                  line_valid_set,
    input  dcache_pkg::word_sel_t wb_beat,
    output logic                  hit,
    output dcache_pkg::way_t      hit_way,
    output dcache_pkg::word_t     hit_word,
    output logic                  victim_dirty,
    output dcache_pkg::tag_t      victim_tag,
    output dcache_pkg::word_t     wb_word
);
    localparam int SETS = 1 << `DC_INDEX_W;

    dcache_pkg::tag_t      tag_mem  [`DC_WAYS][SETS];
    dcache_pkg::word_t     data_mem [`DC_WAYS][SETS][`DC_LINE_WORDS];
    logic [SETS-1:0]       valid_bits [`DC_WAYS];
    logic [SETS-1:0]       dirty_bits [`DC_WAYS];
    dcache_pkg::tag_t      tag_rd  [`DC_WAYS];   // registered lookup results
    dcache_pkg::word_t     word_rd [`DC_WAYS];
    logic [`DC_WAYS-1:0]   valid_rd, dirty_rd, hit_vec;
    dcache_pkg::tag_t      req_tag;
    dcache_pkg::index_t    idx;
    dcache_pkg::word_sel_t off;

    assign req_tag = req_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign idx     = req_addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign off     = req_addr[`DC_OFFSET_W-1:2];

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                tag_rd[w]   <= tag_mem[w][idx];
                word_rd[w]  <= data_mem[w][idx][off];
                valid_rd[w] <= valid_bits[w][idx];
                dirty_rd[w] <= dirty_bits[w][idx];
            end
        end
        // bus asks for the next beat a cycle ahead
        wb_word <= data_mem[victim_way][idx][wb_beat];
    end

    always_ff @(posedge clk) begin
        if (fill_we) data_mem[victim_way][idx][fill_beat] <= fill_wdata;
        if (store_we) begin
            for (int b = 0; b < 4; b++) begin
                if (store_strb[b]) data_mem[store_way][idx][off][8*b +: 8] <= store_wdata[8*b +: 8];
            end
        end
        if (line_valid_set) tag_mem[victim_way][idx] <= req_tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid_bits[w] <= '0;
                dirty_bits[w] <= '0;
            end
        end else begin
            if (line_valid_set) begin
                valid_bits[victim_way][idx] <= 1'b1;
                dirty_bits[victim_way][idx] <= 1'b0;   // clean unless a store follows
            end
            if (store_we) dirty_bits[store_way][idx] <= 1'b1;
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_vec[w] = valid_rd[w] && (tag_rd[w] == req_tag);
            if (hit_vec[w]) hit_way = dcache_pkg::way_t'(w);
        end
    end

    assign hit          = |hit_vec;
    assign hit_word     = word_rd[hit_way];
    assign victim_dirty = valid_rd[victim_way] && dirty_rd[victim_way];
    assign victim_tag   = tag_rd[victim_way];

    // refill only targets missing lines, so a set never holds a tag twice
    single_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec));

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  dcache_pkg::cpu_req_t  req,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output dcache_pkg::word_t     rsp_rdata,
    output dcache_pkg::axi_ar_t   ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  dcache_pkg::word_t     rdata,
    input  logic                  rlast,
    input  logic                  rvalid,
    output logic                  rready,
    output dcache_pkg::axi_aw_t   aw,
    output logic                  awvalid,
    input  logic                  awready,
    output dcache_pkg::axi_w_t    w,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready
);
    dcache_pkg::cpu_req_t  cur_req;
    dcache_pkg::way_t      hit_way, victim_way, plru_way;
    dcache_pkg::tag_t      victim_tag;
    dcache_pkg::word_t     hit_word, fill_wdata, fill_data, wb_word;
    dcache_pkg::word_sel_t fill_beat, wb_beat;
    dcache_pkg::addr_t     refill_addr, wb_addr;
    logic lookup_en, hit, victim_dirty, store_we, fill_we, fill_valid, line_valid_set;
    logic plru_access, refill_start, wb_start, refill_done, wb_done;

    dcache_ctrl dcache_ctrl_inst (
        .clk, .rst, .req_valid, .req, .hit, .hit_way, .victim_way, .victim_dirty,
        .victim_tag, .fill_beat, .fill_valid, .fill_data, .refill_done, .wb_done, .hit_word,
        .req_ready, .rsp_valid, .rsp_rdata, .lookup_en, .cur_req, .store_we, .fill_we,
        .fill_wdata, .line_valid_set, .plru_access, .plru_way, .refill_start, .wb_start,
        .refill_addr, .wb_addr
    );

    dcache_store dcache_store_inst (
        .clk, .rst, .lookup_en, .req_addr(cur_req.addr), .victim_way, .store_we,
        .store_way(plru_way), .store_strb(cur_req.strb), .store_wdata(cur_req.wdata),
        .fill_we, .fill_beat, .fill_wdata, .line_valid_set, .wb_beat,
        .hit, .hit_way, .hit_word, .victim_dirty, .victim_tag, .wb_word
    );

    // tree follows the set of the request being looked up
    dcache_plru dcache_plru_inst (
        .clk, .rst, .index(cur_req.addr[`DC_OFFSET_W +: `DC_INDEX_W]),
        .access(plru_access), .way(plru_way), .victim_way
    );

    dcache_bus dcache_bus_inst (
        .clk, .rst, .refill_start, .refill_addr, .wb_start, .wb_addr, .wb_word,
        .arready, .rdata, .rlast, .rvalid, .awready, .wready, .bvalid,
        .ar, .arvalid, .rready, .fill_beat, .fill_valid, .fill_data, .refill_done,
        .aw, .awvalid, .w, .wvalid, .bready, .wb_beat, .wb_done
    );

endmodule
